// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tbLpPrinterCtrl
FILELIST := vlog.f
OBJDIR   := obj_dir

SIMBIN   := $(OBJDIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard verilog/*.svh)

.PHONY: all run clean

all: $(SIMBIN)

# Rebuilt only when a source or the file list changes
$(SIMBIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Exit status of the binary is the test result
run: $(SIMBIN)
	./$(SIMBIN)

clean:
	rm -rf $(OBJDIR)

// File: bench/lpPrinterCtrl_props.sv
// Port rules of the DMA and printer interfaces bound into the top level
// An init write may drop a pending request without an ack
`timescale 1ns/1ps
`include "lp20_settings.svh"

module lpPrinterCtrl_props (
   input logic          clk,
   input logic          rstN,
   input lpPkg::regSelT regSel,
   input logic          regWrite,
   input lpPkg::wordT   regWdata,
   input logic          dmaReq,
   input lpPkg::addrT   dmaAddr,
   input logic          dmaAck,
   input logic          printReady,
   input logic          printStrobe,
   input logic          intr
);

   import lpPkg::*;

   // Abort strobe is the only legal way to drop a request early
   logic initWrite;

   assign initWrite = regWrite && (regSel == regCsr) && regWdata[`LP_CSR_INIT];

   //////////////////////////////
   // DMA port
   //////////////////////////////

   // Request stays up with a steady address until the ack
   reqHeld: assert property (@(posedge clk) disable iff (!rstN)
      dmaReq && !dmaAck && !initWrite |=> dmaReq && $stable(dmaAddr))
      else $error("dmaReq dropped or dmaAddr moved before dmaAck");

   // Request released once the word arrives
   ackEndsReq: assert property (@(posedge clk) disable iff (!rstN) dmaAck |=> !dmaReq)
      else $error("dmaReq still high in the cycle after dmaAck");

   //////////////////////////////
   // Printer port and reset
   //////////////////////////////

   // No strobe into a stalled printer
   strobeReady: assert property (@(posedge clk) disable iff (!rstN)
      printStrobe |-> printReady)
      else $error("printStrobe while printReady low");

   // Reset leaves every output quiet
   quietReset: assert property (@(posedge clk) !rstN |=> !dmaReq && !printStrobe && !intr)
      else $error("output active in the cycle after reset");

endmodule

bind lpPrinterCtrl lpPrinterCtrl_props props (
   .clk(clk), .rstN(rstN),
   .regSel(regSel), .regWrite(regWrite), .regWdata(regWdata),
   .dmaReq(dmaReq), .dmaAddr(dmaAddr), .dmaAck(dmaAck),
   .printReady(printReady), .printStrobe(printStrobe), .intr(intr)
);

// File: bench/tbLpPrinterCtrl.sv
// Runs a table of print jobs through the printer DMA controller
// Memory latency and printer readiness are random from a fixed seed
// The first failed check ends the run
`timescale 1ns/1ps
`include "lp20_settings.svh"

module tbLpPrinterCtrl;

   import lpPkg::*;

   typedef struct packed {
      addrT        bar;
      bctrT        bctr;
      logic        intEna;
      logic [15:0] abortAfter;   // strobes before init or zero for a full job
   } jobT;

   localparam int NumJobs   = 7;
   localparam int WaitLimit = 30000;

   logic   clk;
   logic   rstN;
   regSelT regSel;
   logic   regWrite;
   logic   regRead;
   wordT   regWdata;
   wordT   regRdata;
   logic   dmaReq;
   addrT   dmaAddr;
   logic   dmaAck;
   wordT   dmaData;
   logic   printReady;
   logic   printStrobe;
   byteT   printData;
   logic   intr;

   integer seed = 32'h4a61;
   int     ackWait;
   addrT   reqAddr;
   int     printed = 0;
   byteT   expQ[$];
   jobT    jobs [NumJobs];

   lpPrinterCtrl i_lpPrinterCtrl (.*);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //////////////////////////////
   // Helpers
   //////////////////////////////

   // Fill pattern with every address bit in the printed bits 35:4
   function automatic wordT memWord(input addrT addr);
      return {addr ^ 18'h2a5c3, addr * 18'd13 + 18'h00c35};
   endfunction

   task automatic failRun(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic checkValue(input string name, input wordT got, input wordT exp);
      assert (got == exp)
      else
         failRun($sformatf("[ERROR] %0t: %s = %h, expected %h", $time, name, got, exp));
   endtask

   // Inputs change 1 ns after the edge
   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic writeReg(input regSelT sel, input wordT data);
      regSel   = sel;
      regWdata = data;
      regWrite = 1'b1;
      tick();
      regWrite = 1'b0;
   endtask

   // Read data is valid the cycle after the strobe
   task automatic readReg(input regSelT sel, output wordT data);
      regSel  = sel;
      regRead = 1'b1;
      tick();
      regRead = 1'b0;
      data    = regRdata;
   endtask

   task automatic checkReg(input regSelT sel, input wordT exp, input string name);
      wordT got;
      readReg(sel, got);
      checkValue(name, got, exp);
   endtask

   // Expected stream in address order with the top byte first
   task automatic queueBytes(input addrT bar, input int total);
      wordT w;
      int   pos;
      for (int i = 0; i < total; i++)
      begin
         w   = memWord(addrT'(bar + i / `LP_BYTES_PER_WORD));
         pos = `LP_WORD_WIDTH - 1 - (i % `LP_BYTES_PER_WORD) * `LP_BYTE_WIDTH;
         expQ.push_back(w[pos -: `LP_BYTE_WIDTH]);
      end
   endtask

   //////////////////////////////
   // Memory and printer models
   //////////////////////////////

   // Ack after 1 to 4 request cycles with a steady address
   initial
   begin
      dmaAck     = 1'b0;
      dmaData    = '0;
      printReady = 1'b0;
      ackWait    = 0;
      reqAddr    = '0;
      forever
      begin
         tick();
         printReady = ($unsigned($random(seed)) % 4) != 0;
         if (dmaAck)
            dmaAck = 1'b0;
         else if (dmaReq)
         begin
            if (ackWait == 0)
            begin
               ackWait = 1 + $unsigned($random(seed)) % 4;
               reqAddr = dmaAddr;
            end
            else
               checkValue("dmaAddr", wordT'(dmaAddr), wordT'(reqAddr));
            ackWait--;
            if (ackWait == 0)
            begin
               dmaAck  = 1'b1;
               dmaData = memWord(dmaAddr);
            end
         end
         else
            ackWait = 0;   // request dropped by an init abort
      end
   end

   // Printer side sampled mid cycle where all is settled
   always @(negedge clk)
   begin
      if (printStrobe)
      begin
         assert (printReady) else failRun("printStrobe came while printReady was low");
         assert (expQ.size() != 0) else failRun("printStrobe with no byte left to print");
         checkValue("printData", wordT'(printData), wordT'(expQ.pop_front()));
         printed++;
      end
   end

   //////////////////////////////
   // Jobs
   //////////////////////////////

   // Init mid job must leave no requests, no strobes and all registers zero
   task automatic abortJob(input int stopAt);
      int   guard;
      wordT initWord;
      guard    = 0;
      initWord = '0;
      initWord[`LP_CSR_INIT] = 1'b1;
      while (printed < stopAt && guard < WaitLimit)
      begin
         tick();
         guard++;
      end
      assert (printed >= stopAt) else failRun("timeout waiting for strobes before init");
      writeReg(regCsr, initWord);
      // A strobe in the init cycle itself was still checked
      expQ.delete();
      repeat (8)
      begin
         tick();
         assert (!dmaReq) else failRun("dmaReq raised after init");
      end
      checkReg(regCsr, '0, "CSR");
      checkReg(regBar, '0, "BAR");
      checkReg(regBctr, '0, "BCTR");
      checkValue("intr", wordT'(intr), '0);
   endtask

   task automatic runJob(input jobT job);
      int   total;
      int   words;
      int   base;
      int   guard;
      logic wrapExp;
      wordT csr;
      wordT ctl;
      // Loaded count of zero means a full 4096 bytes
      total   = (job.bctr == '0) ? 4096 : 4096 - int'(job.bctr);
      words   = (total + `LP_BYTES_PER_WORD - 1) / `LP_BYTES_PER_WORD;
      wrapExp = (int'(job.bar) + words) >= (1 << `LP_ADDR_WIDTH);
      base    = printed;
      ctl     = '0;
      ctl[`LP_CSR_GO]     = 1'b1;
      ctl[`LP_CSR_INTENA] = job.intEna;
      queueBytes(job.bar, total);
      writeReg(regBar, wordT'(job.bar));
      writeReg(regBctr, wordT'(job.bctr));
      writeReg(regCsr, ctl);
      assert (dmaReq) else failRun("dmaReq not raised in the cycle after go");
      if (job.abortAfter != '0)
         abortJob(base + int'(job.abortAfter));
      else
      begin
         guard = 0;
         csr   = '0;
         while (!csr[`LP_CSR_DONE] && guard < WaitLimit)
         begin
            readReg(regCsr, csr);
            guard++;
         end
         assert (csr[`LP_CSR_DONE]) else failRun("timeout waiting for done");
         checkValue("bytes printed", wordT'(printed - base), wordT'(total));
         // Busy clear and done set with wrap only if a fetch hit the top address
         ctl = '0;
         ctl[`LP_CSR_INTENA]   = job.intEna;
         ctl[`LP_CSR_DONE]     = 1'b1;
         ctl[`LP_CSR_ADDRWRAP] = wrapExp;
         checkReg(regCsr, ctl, "CSR");
         checkReg(regBctr, '0, "BCTR");
         checkReg(regBar, wordT'(addrT'(int'(job.bar) + words)), "BAR");
         checkValue("intr", wordT'(intr), wordT'(job.intEna));
      end
   endtask

   initial
   begin
      rstN     = 1'b0;
      regSel   = regCsr;
      regWrite = 1'b0;
      regRead  = 1'b0;
      regWdata = '0;
      // bar, bctr, intEna, abortAfter
      jobs[0] = '{18'h00100, 12'hff0, 1'b1, 16'd0};
      jobs[1] = '{18'h01234, 12'hff3, 1'b0, 16'd0};    // partial last word
      jobs[2] = '{18'h3ffff, 12'hff9, 1'b1, 16'd0};    // two words across the top
      jobs[3] = '{18'h20000, 12'hfff, 1'b0, 16'd0};
      jobs[4] = '{18'h00400, 12'hf00, 1'b1, 16'd37};
      jobs[5] = '{18'h3fff0, 12'h000, 1'b1, 16'd0};    // full 4096 bytes
      jobs[6] = '{18'h3fffe, 12'hff8, 1'b0, 16'd0};    // last word at the top address
      repeat (5) @(posedge clk);
      #1;
      rstN = 1'b1;
      assert (!dmaReq && !printStrobe && !intr) else failRun("DUT outputs active after reset");
      checkReg(regCsr, '0, "CSR");
      checkReg(regBar, '0, "BAR");
      checkReg(regBctr, '0, "BCTR");
      for (int j = 0; j < NumJobs; j++)
         runJob(jobs[j]);
      $display("Result: PASSED");
      $finish;
   end

endmodule

// File: verilog/lp20_settings.svh
// Field widths and CSR bit positions for the printer DMA controller
// Word layout follows the 36-bit host with bytes packed in bits 35:4
`ifndef LP20_SETTINGS_SVH
`define LP20_SETTINGS_SVH

//////////////////////////////
// Field widths
//////////////////////////////

// Byte count register width
`define LP_BCTR_WIDTH      12
// Bus word address width
`define LP_ADDR_WIDTH      18
// Memory and host data word
`define LP_WORD_WIDTH      36
// One printer character
`define LP_BYTE_WIDTH      8
// Bytes unpacked from each word
`define LP_BYTES_PER_WORD  4

//////////////////////////////
// CSR bit positions
//////////////////////////////

`define LP_CSR_GO          0
`define LP_CSR_INIT        1
`define LP_CSR_INTENA      2
`define LP_CSR_BUSY        3
`define LP_CSR_DONE        4
`define LP_CSR_ADDRWRAP    5

`endif

// File: verilog/lpByteUnpack.sv
// Holds one fetched word and hands out its bytes, MSB first
// Bytes sit left justified in bits 35:4, bits 3:0 are not printed
// byteValid rises the cycle after wordLoad
`timescale 1ns/1ps
`include "lp20_settings.svh"

module lpByteUnpack (
   input  logic        clk,
   input  logic        rstN,
   input  logic        flush,
   input  logic        wordLoad,
   input  lpPkg::wordT wordData,
   input  logic        byteTake,
   output logic        byteValid,
   output lpPkg::byteT byteData,
   output logic        lastByte
);

   import lpPkg::*;

   localparam int IdxWidth = $clog2(`LP_BYTES_PER_WORD);
   localparam int LastIdx  = `LP_BYTES_PER_WORD - 1;

   // Fetched word, payload only
   wordT                wordReg;
   // Position of the byte on offer
   logic [IdxWidth-1:0] byteIdx;
   // Bytes remain in wordReg
   logic                held;

   //////////////////////////////
   // Word holding register
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (wordLoad)
         wordReg <= wordData;
   end

   //////////////////////////////
   // Byte index and valid flag
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!rstN || flush)
      begin
         held    <= 1'b0;
         byteIdx <= '0;
      end
      else if (wordLoad)
      begin
         // New word starts at its most significant byte
         held    <= 1'b1;
         byteIdx <= '0;
      end
      else if (byteTake && held)
      begin
         // Last byte taken empties the holder
         if (byteIdx == IdxWidth'(LastIdx))
            held <= 1'b0;
         else
            byteIdx <= byteIdx + 1'b1;
      end
   end

   //////////////////////////////
   // Byte select
   //////////////////////////////

   // Index 0 is bits 35:28, index 3 is bits 11:4
   assign byteData  = wordReg[`LP_WORD_WIDTH-1 - byteIdx*`LP_BYTE_WIDTH -: `LP_BYTE_WIDTH];
   assign byteValid = held;
   // Fourth byte of the word on offer
   assign lastByte  = held && (byteIdx == IdxWidth'(LastIdx));

endmodule

// File: verilog/lpControl.sv
// Register decode, CSR and fetch/print sequencer
// BAR and BCTR writes are dropped while a job runs
// An init write aborts any job and clears all status
`timescale 1ns/1ps
`include "lp20_settings.svh"

module lpControl (
   input  logic          clk,
   input  logic          rstN,
   input  lpPkg::regSelT regSel,
   input  logic          regWrite,
   input  logic          regRead,
   input  lpPkg::wordT   regWdata,
   output lpPkg::wordT   regRdata,
   input  lpPkg::addrT   barCount,
   input  lpPkg::bctrT   bctrCount,
   input  logic          barWrap,
   input  logic          bctrWrap,
   output logic          lpInit,
   output logic          barLoad,
   output logic          bctrLoad,
   output logic          barInc,
   output logic          bctrInc,
   output logic          dmaReq,
   input  logic          dmaAck,
   output logic          wordLoad,
   output logic          byteTake,
   output logic          flush,
   input  logic          byteValid,
   input  logic          lastByte,
   input  logic          printReady,
   output logic          printStrobe,
   output logic          intr
);

   import lpPkg::*;

   // Sequencer states
   typedef enum logic [1:0] {stIdle, stFetch, stPrint} stateT;

   stateT state;
   logic  intEnable;
   logic  done;
   logic  addrWrap;
   logic  busy;
   logic  csrWrite;
   logic  goStart;
   logic  jobEnd;
   wordT  readMux;

   //////////////////////////////
   // Register write decode
   //////////////////////////////

   assign csrWrite = regWrite && (regSel == regCsr);
   // Init wins over every other CSR field
   assign lpInit   = csrWrite && regWdata[`LP_CSR_INIT];
   assign busy     = (state != stIdle);
   // Go is honoured only from idle
   assign goStart  = csrWrite && !regWdata[`LP_CSR_INIT] && regWdata[`LP_CSR_GO] && !busy;
   assign barLoad  = regWrite && (regSel == regBar) && !busy;
   assign bctrLoad = regWrite && (regSel == regBctr) && !busy;

   //////////////////////////////
   // DMA and printer strobes
   //////////////////////////////

   // Request held for the whole fetch state
   assign dmaReq      = (state == stFetch);
   assign wordLoad    = dmaReq && dmaAck;
   // One bus address step per fetched word
   assign barInc      = wordLoad;
   // Back pressure holds the byte while printReady is low
   assign printStrobe = (state == stPrint) && byteValid && printReady;
   assign byteTake    = printStrobe;
   assign bctrInc     = printStrobe;
   // Count wrap on the strobed byte ends the job
   assign jobEnd      = printStrobe && bctrWrap;
   // Drop any leftover bytes of a partial last word
   assign flush       = lpInit || jobEnd;
   assign intr        = done && intEnable;

   //////////////////////////////
   // Sequencer
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!rstN || lpInit)
         state <= stIdle;
      else
      begin
         case (state)
            stIdle:
               if (goStart)
                  state <= stFetch;
            stFetch:
               if (dmaAck)
                  state <= stPrint;
            stPrint:
               if (jobEnd)
                  state <= stIdle;
               else if (printStrobe && lastByte)
                  state <= stFetch;   // word used up, fetch next
            default:
               state <= stIdle;
         endcase
      end
   end

   //////////////////////////////
   // Status bits
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!rstN || lpInit)
      begin
         intEnable <= 1'b0;
         done      <= 1'b0;
         addrWrap  <= 1'b0;
      end
      else
      begin
         // Any CSR write updates the enable
         if (csrWrite)
            intEnable <= regWdata[`LP_CSR_INTENA];
         // New job clears the previous result
         if (goStart)
         begin
            done     <= 1'b0;
            addrWrap <= 1'b0;
         end
         if (jobEnd)
            done <= 1'b1;
         if (barWrap)
            addrWrap <= 1'b1;
      end
   end

   //////////////////////////////
   // Read data
   //////////////////////////////

   always_comb
   begin
      readMux = '0;
      case (regSel)
         regCsr:
         begin
            // Go and init always read back as zero
            readMux[`LP_CSR_INTENA]   = intEnable;
            readMux[`LP_CSR_BUSY]     = busy;
            readMux[`LP_CSR_DONE]     = done;
            readMux[`LP_CSR_ADDRWRAP] = addrWrap;
         end
         regBar:
            readMux = wordT'(barCount);
         regBctr:
            readMux = wordT'(bctrCount);
         default:
            readMux = '0;
      endcase
   end

   // Captured on the read strobe and held until the next one
   always_ff @(posedge clk)
   begin
      if (!rstN)
         regRdata <= '0;
      else if (regRead)
         regRdata <= readMux;
   end

endmodule

// File: verilog/lpCounter.sv
// Loadable up counter with a wrap pulse
// countT must be a packed vector type
// Priority is clear, then load, then increment
`timescale 1ns/1ps

module lpCounter #(
   parameter type countT = logic [7:0]
) (
   input  logic  clk,
   input  logic  rstN,
   input  logic  clear,
   input  logic  load,
   input  countT loadValue,
   input  logic  inc,
   output countT count,
   output logic  wrap
);

   //////////////////////////////
   // Count register
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      // Reset and controller init both zero the count
      if (!rstN || clear)
         count <= '0;
      else if (load)
         count <= loadValue;
      else if (inc)
         count <= count + 1'b1;
   end

   //////////////////////////////
   // Wrap detect
   //////////////////////////////

   // Increment from all ones
   // Same cycle as the increment, not registered
   assign wrap = inc && (count == '1);

endmodule

// File: verilog/lpPkg.sv
// Shared data types for the printer DMA controller
// Widths come from the settings header
`include "lp20_settings.svh"

package lpPkg;

   //////////////////////////////
   // Data types
   //////////////////////////////

   // Byte count value, wraps to zero at the end of a job
   typedef logic [`LP_BCTR_WIDTH-1:0] bctrT;

   // Bus word address
   typedef logic [`LP_ADDR_WIDTH-1:0] addrT;

   // Memory word and host register data
   typedef logic [`LP_WORD_WIDTH-1:0] wordT;

   // One character to the printer
   typedef logic [`LP_BYTE_WIDTH-1:0] byteT;

   // Host register select
   typedef enum logic [1:0] {
      regCsr  = 2'd0,
      regBar  = 2'd1,
      regBctr = 2'd2
   } regSelT;

endpackage

// File: verilog/lpPrinterCtrl.sv
// Printer DMA controller top level
// Memory port answers dmaReq with a one cycle dmaAck
// Printer takes a byte on each printStrobe
`timescale 1ns/1ps
`include "lp20_settings.svh"

module lpPrinterCtrl (
   input  logic          clk,
   input  logic          rstN,
   input  lpPkg::regSelT regSel,
   input  logic          regWrite,
   input  logic          regRead,
   input  lpPkg::wordT   regWdata,
   output lpPkg::wordT   regRdata,
   output logic          dmaReq,
   output lpPkg::addrT   dmaAddr,
   input  logic          dmaAck,
   input  lpPkg::wordT   dmaData,
   input  logic          printReady,
   output logic          printStrobe,
   output lpPkg::byteT   printData,
   output logic          intr
);

   import lpPkg::*;

   // Counter controls
   logic lpInit;
   logic barLoad;
   logic bctrLoad;
   logic barInc;
   logic bctrInc;
   logic barWrap;
   logic bctrWrap;
   bctrT bctrCount;

   // Unpacker handshake
   logic wordLoad;
   logic byteTake;
   logic flush;
   logic byteValid;
   logic lastByte;

   //////////////////////////////
   // Controller
   //////////////////////////////

   lpControl control (
      .clk(clk), .rstN(rstN),
      .regSel(regSel), .regWrite(regWrite), .regRead(regRead),
      .regWdata(regWdata), .regRdata(regRdata),
      .barCount(dmaAddr), .bctrCount(bctrCount),
      .barWrap(barWrap), .bctrWrap(bctrWrap),
      .lpInit(lpInit), .barLoad(barLoad), .bctrLoad(bctrLoad),
      .barInc(barInc), .bctrInc(bctrInc),
      .dmaReq(dmaReq), .dmaAck(dmaAck),
      .wordLoad(wordLoad), .byteTake(byteTake), .flush(flush),
      .byteValid(byteValid), .lastByte(lastByte),
      .printReady(printReady), .printStrobe(printStrobe),
      .intr(intr)
   );

   //////////////////////////////
   // Byte count and bus address
   //////////////////////////////

   lpCounter #(.countT(bctrT)) byteCount (
      .clk(clk), .rstN(rstN), .clear(lpInit),
      .load(bctrLoad), .loadValue(regWdata[`LP_BCTR_WIDTH-1:0]),
      .inc(bctrInc), .count(bctrCount), .wrap(bctrWrap)
   );

   // Its count drives the memory address directly
   lpCounter #(.countT(addrT)) busAddr (
      .clk(clk), .rstN(rstN), .clear(lpInit),
      .load(barLoad), .loadValue(regWdata[`LP_ADDR_WIDTH-1:0]),
      .inc(barInc), .count(dmaAddr), .wrap(barWrap)
   );

   //////////////////////////////
   // Word to byte unpacker
   //////////////////////////////

   lpByteUnpack unpack (
      .clk(clk), .rstN(rstN), .flush(flush),
      .wordLoad(wordLoad), .wordData(dmaData),
      .byteTake(byteTake), .byteValid(byteValid),
      .byteData(printData), .lastByte(lastByte)
   );

endmodule

// File: vlog.f
+incdir+verilog
verilog/lpPkg.sv
verilog/lpCounter.sv
verilog/lpByteUnpack.sv
verilog/lpControl.sv
verilog/lpPrinterCtrl.sv
bench/lpPrinterCtrl_props.sv
bench/tbLpPrinterCtrl.sv
